//--- tb.f
fp_pkg.sv
fp_operand_unpack.sv
fp_mantissa_multiply.sv
fp_normalize_round.sv
fp_mul_top.sv
fp_mul_checker.sv
tb_fp_mul.sv

//--- Bender.yml
package:
  name: fp_mul

sources:
  - fp_pkg.sv
  - fp_operand_unpack.sv
  - fp_mantissa_multiply.sv
  - fp_normalize_round.sv
  - fp_mul_top.sv
  - target: test
    files:
      - fp_mul_checker.sv
      - tb_fp_mul.sv

//--- tb_fp_mul.sv
// fp32 multiplier testbench
`timescale 1ns/1ps

module tb_fp_mul import fp_pkg::*; ();

	logic             clk = 1'b0;
	logic             reset;
	logic             start;
	logic [FLEN-1:0]  in_1;
	logic [FLEN-1:0]  in_2;
	rnd_mode_t        rnd;
	logic [TAG_W-1:0] rd;
	logic             valid;
	logic [FLEN-1:0]  res;
	logic [4:0]       exceptions;
	logic [TAG_W-1:0] rd_out;
	logic             run_end;
	int               checks;
	int               errors;
	int               pending;
	int               n_tests = 0;
	int               timeouts = 0;
	int               checks_at;
	int               errors_at;

	// qnan, snan, +inf, -inf, +0, -0, subnormal, finite
	logic [31:0] special_ops [8] = '{32'h7fc00000, 32'h7f800001, 32'h7f800000, 32'hff800000,
		32'h00000000, 32'h80000000, 32'h00000001, 32'hbfc00000};
	// pairs at the edges of the exponent range
	logic [31:0] range_a [9] = '{32'h7f000000, 32'h7f7fffff, 32'h7f7fffff, 32'h5f800000,
		32'h7effffff, 32'h00800000, 32'h3f7fffff, 32'h00800001, 32'h1f800000};
	logic [31:0] range_b [9] = '{32'h40000000, 32'h3f800001, 32'h7f7fffff, 32'h5f800000,
		32'h40000000, 32'h3f000000, 32'h00800000, 32'h3f7fffff, 32'h1f800000};

	always #4 clk = ~clk;

	fp_mul_top i_dut (.clk, .reset, .start, .in_1, .in_2, .rnd, .rd,
		.valid, .res, .exceptions, .rd_out);

	fp_mul_checker i_checker (.clk, .reset, .start, .in_1, .in_2, .rnd, .rd,
		.valid, .res, .exceptions, .rd_out, .run_end, .checks, .errors, .pending);

	task automatic issue(input logic [31:0] a, input logic [31:0] b, input rnd_mode_t mode,
		input logic [TAG_W-1:0] tag);
		@(posedge clk);
		start <= 1'b1;
		in_1  <= a;
		in_2  <= b;
		rnd   <= mode;
		rd    <= tag;
	endtask

	task automatic begin_test();
		checks_at = checks;
		errors_at = errors;
	endtask

	// stop issuing, then wait for the pipe to drain
	task automatic finish_test(input string name);
		int tmo;
		@(posedge clk);
		start <= 1'b0;
		tmo = 0;
		do begin
			@(negedge clk);
			tmo++;
		end while (pending != 0 && tmo < 20);
		if (pending != 0) begin
			$display("timed out in test %s with %0d results outstanding", name, pending);
			timeouts++;
		end else begin
			n_tests++;
			$display("test %s: %0d checks, %0d errors", name, checks - checks_at,
				errors - errors_at);
		end
	endtask

	initial begin
		logic [31:0] a;
		logic [31:0] b;
		reset   = 1'b1;
		start   = 1'b0;
		in_1    = '0;
		in_2    = '0;
		rnd     = RNE;
		rd      = '0;
		run_end = 1'b0;
		void'($urandom(32'hbc73c1bb));
		repeat (16) @(posedge clk);
		reset <= 1'b0;

		begin_test();
		repeat (5) @(posedge clk);	// valid must stay low here
		issue(32'h3fc00000, 32'h40000000, RNE, 6'd5);
		issue(32'h40400000, 32'h3f000000, RTZ, 6'd42);
		finish_test("reset_latency");

		begin_test();
		for (int m = 0; m < 5; m++) begin
			issue(32'h3fc00000, 32'h40000000, rnd_mode_t'(m), 6'(m));
			issue(32'h40400000, 32'h3eaaaaab, rnd_mode_t'(m), 6'(m + 8));
			issue(32'hc0400000, 32'h3eaaaaab, rnd_mode_t'(m), 6'(m + 16));
			issue(32'h3f8ccccd, 32'h3f8ccccd, rnd_mode_t'(m), 6'(m + 24));
			issue(32'hbf8ccccd, 32'h3f8ccccd, rnd_mode_t'(m), 6'(m + 32));
		end
		finish_test("directed_rounding");

		begin_test();
		for (int i = 0; i < 500; i++) begin
			a = {1'($urandom), 8'($urandom_range(190, 64)), 23'($urandom)};
			b = {1'($urandom), 8'($urandom_range(190, 64)), 23'($urandom)};
			issue(a, b, rnd_mode_t'($urandom_range(4, 0)), 6'($urandom));
		end
		finish_test("random_stream");

		begin_test();
		for (int i = 0; i < 8; i++)
			for (int j = 0; j < 8; j++)
				issue(special_ops[i], special_ops[j], RNE, 6'(i * 8 + j));
		finish_test("special_values");

		begin_test();
		for (int k = 0; k < 9; k++)
			for (int m = 0; m < 5; m++)
				for (int s = 0; s < 2; s++)
					issue({range_a[k][31] ^ 1'(s), range_a[k][30:0]}, range_b[k],
						rnd_mode_t'(m), 6'(k * 10 + m * 2 + s));
		finish_test("exponent_range");

		run_end = 1'b1;	// checker looks for leftovers
		@(posedge clk);
		@(negedge clk);
		$display("%0d tests, %0d checks, %0d errors", n_tests, checks, errors + timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

//--- fp_mul_checker.sv
// fp32 multiplier result checker
`timescale 1ns/1ps

module fp_mul_checker import fp_pkg::*; (
	input  logic             clk,
	input  logic             reset,
	input  logic             start,
	input  logic [FLEN-1:0]  in_1,
	input  logic [FLEN-1:0]  in_2,
	input  rnd_mode_t        rnd,
	input  logic [TAG_W-1:0] rd,
	input  logic             valid,
	input  logic [FLEN-1:0]  res,
	input  logic [4:0]       exceptions,
	input  logic [TAG_W-1:0] rd_out,
	input  logic             run_end,
	output int               checks,
	output int               errors,
	output int               pending
);

	logic [36:0]      exp_q [$];	// {flags, result}
	logic [TAG_W-1:0] tag_q [$];
	int               cyc_q [$];
	int               cycle = 0;
	int               n_checks = 0;
	int               n_errors = 0;
	int               n_pending = 0;
	logic             end_seen = 1'b0;

	assign checks  = n_checks;
	assign errors  = n_errors;
	assign pending = n_pending;

	// expected {flags, result}, remainder compared against half an ulp
	function automatic logic [36:0] ref_mul(logic [31:0] a, logic [31:0] b, rnd_mode_t mode);
		logic        sign;
		logic [7:0]  ea;
		logic [7:0]  eb;
		logic        nan_a;
		logic        nan_b;
		logic        snan;
		logic [47:0] p;
		logic [47:0] q;
		logic [47:0] rem;
		logic [47:0] half;
		logic        up;
		logic [4:0]  fl;
		int          sh;
		int          e;
		sign  = a[31] ^ b[31];
		ea    = a[30:23];
		eb    = b[30:23];
		nan_a = ea == 8'hff && a[22:0] != 0;
		nan_b = eb == 8'hff && b[22:0] != 0;
		snan  = (nan_a && !a[22]) || (nan_b && !b[22]);
		fl    = '0;
		if (nan_a || nan_b) begin
			fl[FLAG_NV] = snan;
			return {fl, QNAN};
		end
		if ((ea == 8'hff && eb == 0) || (eb == 8'hff && ea == 0)) begin
			fl[FLAG_NV] = 1'b1;	// inf * 0
			return {fl, QNAN};
		end
		if (ea == 8'hff || eb == 8'hff)
			return {fl, sign, 8'hff, 23'd0};
		if (ea == 0 || eb == 0)
			return {fl, sign, 31'd0};	// subnormals count as zero
		p    = {24'd0, 1'b1, a[22:0]} * {24'd0, 1'b1, b[22:0]};
		sh   = p[47] ? 24 : 23;	// keep 24 significant bits
		e    = int'(ea) + int'(eb) - 127 + (p[47] ? 1 : 0);
		q    = p >> sh;
		rem  = p & ((48'd1 << sh) - 48'd1);
		half = 48'd1 << (sh - 1);
		case (mode)
			RNE: up = rem > half || (rem == half && q[0]);
			RTZ: up = 1'b0;
			RDN: up = rem != 0 && sign;
			RUP: up = rem != 0 && !sign;
			RMM: up = rem >= half;
			default: up = 1'b0;
		endcase
		q = q + 48'(up);
		if (q[24]) begin
			q = q >> 1;
			e = e + 1;
		end
		if (e > 254) begin
			fl[FLAG_OF] = 1'b1;
			fl[FLAG_NX] = 1'b1;
			if (mode == RNE || mode == RMM || (mode == RUP && !sign) || (mode == RDN && sign))
				return {fl, sign, 8'hff, 23'd0};
			return {fl, sign, 8'hfe, 23'h7fffff};
		end
		if (e < 1) begin
			fl[FLAG_UF] = 1'b1;
			fl[FLAG_NX] = 1'b1;
			return {fl, sign, 31'd0};
		end
		fl[FLAG_NX] = rem != 0;
		return {fl, sign, 8'(e), q[22:0]};
	endfunction

	task automatic check_result();
		logic [36:0]      exp_word;
		logic [TAG_W-1:0] exp_tag;
		int               start_cycle;
		if (exp_q.size() == 0) begin
			$display("valid was high with no operation in flight");
			n_errors++;
			return;
		end
		exp_word    = exp_q.pop_front();
		exp_tag     = tag_q.pop_front();
		start_cycle = cyc_q.pop_front();
		n_checks++;
		if (res !== exp_word[31:0]) begin
			$display("mismatch res: got %h expected %h (tag %h)", res, exp_word[31:0], exp_tag);
			n_errors++;
		end
		if (exceptions !== exp_word[36:32]) begin
			$display("mismatch exceptions: got %h expected %h (tag %h)",
				exceptions, exp_word[36:32], exp_tag);
			n_errors++;
		end
		if (rd_out !== exp_tag) begin
			$display("mismatch rd_out: got %h expected %h", rd_out, exp_tag);
			n_errors++;
		end
		if (cycle - start_cycle != 2) begin
			$display("result for tag %h came %0d cycles after its start instead of 2",
				exp_tag, cycle - start_cycle);
			n_errors++;
		end
	endtask

	always @(posedge clk) begin
		if (!reset) begin
			cycle++;
			if (valid !== 1'b0)
				check_result();	// pop before this edge's push
			if (start) begin
				exp_q.push_back(ref_mul(in_1, in_2, rnd));
				tag_q.push_back(rd);
				cyc_q.push_back(cycle);
			end
			if (run_end && !end_seen) begin
				end_seen = 1'b1;
				if (exp_q.size() != 0) begin
					$display("%0d operations never produced a result", exp_q.size());
					n_errors++;
				end
			end
			n_pending = exp_q.size();
		end
	end

endmodule

//--- fp_mul_top.sv
// pipelined fp32 multiplier
`timescale 1ns/1ps

module fp_mul_top import fp_pkg::*; (
	input  logic             clk,
	input  logic             reset,
	input  logic             start,
	input  logic [FLEN-1:0]  in_1,
	input  logic [FLEN-1:0]  in_2,
	input  rnd_mode_t        rnd,
	input  logic [TAG_W-1:0] rd,
	output logic             valid,
	output logic [FLEN-1:0]  res,
	output logic [4:0]       exceptions,
	output logic [TAG_W-1:0] rd_out
);

	// stage b, unpacked operands
	logic                        b_valid;
	logic                        b_sign;
	logic signed [EXP_SUM_W-1:0] b_exp_sum;
	logic [MANT_W-1:0]           b_mant_1;
	logic [MANT_W-1:0]           b_mant_2;
	logic                        b_special_nan;
	logic                        b_special_nv;
	logic                        b_special_inf;
	logic                        b_special_zero;
	rnd_mode_t                   b_rnd;
	logic [TAG_W-1:0]            b_rd;

	// stage c, raw product
	logic                        c_valid;
	logic                        c_sign;
	logic signed [EXP_SUM_W-1:0] c_exp_sum;
	logic [PROD_W-1:0]           c_product;
	logic                        c_special_nan;
	logic                        c_special_nv;
	logic                        c_special_inf;
	logic                        c_special_zero;
	rnd_mode_t                   c_rnd;
	logic [TAG_W-1:0]            c_rd;

	fp_operand_unpack i_unpack (
		.clk            (clk),
		.reset          (reset),
		.start          (start),
		.in_1           (in_1),
		.in_2           (in_2),
		.rnd            (rnd),
		.rd             (rd),
		.b_valid        (b_valid),
		.b_sign         (b_sign),
		.b_exp_sum      (b_exp_sum),
		.b_mant_1       (b_mant_1),
		.b_mant_2       (b_mant_2),
		.b_special_nan  (b_special_nan),
		.b_special_nv   (b_special_nv),
		.b_special_inf  (b_special_inf),
		.b_special_zero (b_special_zero),
		.b_rnd          (b_rnd),
		.b_rd           (b_rd)
	);

	fp_mantissa_multiply i_multiply (
		.clk            (clk),
		.reset          (reset),
		.b_valid        (b_valid),
		.b_sign         (b_sign),
		.b_exp_sum      (b_exp_sum),
		.b_mant_1       (b_mant_1),
		.b_mant_2       (b_mant_2),
		.b_special_nan  (b_special_nan),
		.b_special_nv   (b_special_nv),
		.b_special_inf  (b_special_inf),
		.b_special_zero (b_special_zero),
		.b_rnd          (b_rnd),
		.b_rd           (b_rd),
		.c_valid        (c_valid),
		.c_sign         (c_sign),
		.c_exp_sum      (c_exp_sum),
		.c_product      (c_product),
		.c_special_nan  (c_special_nan),
		.c_special_nv   (c_special_nv),
		.c_special_inf  (c_special_inf),
		.c_special_zero (c_special_zero),
		.c_rnd          (c_rnd),
		.c_rd           (c_rd)
	);

	fp_normalize_round i_round (
		.c_valid        (c_valid),
		.c_sign         (c_sign),
		.c_exp_sum      (c_exp_sum),
		.c_product      (c_product),
		.c_special_nan  (c_special_nan),
		.c_special_nv   (c_special_nv),
		.c_special_inf  (c_special_inf),
		.c_special_zero (c_special_zero),
		.c_rnd          (c_rnd),
		.c_rd           (c_rd),
		.valid          (valid),
		.res            (res),
		.exceptions     (exceptions),
		.rd_out         (rd_out)
	);

endmodule

//--- fp_normalize_round.sv
// normalize, round and pack
`timescale 1ns/1ps

module fp_normalize_round import fp_pkg::*; (
	input  logic                        c_valid,
	input  logic                        c_sign,
	input  logic signed [EXP_SUM_W-1:0] c_exp_sum,
	input  logic [PROD_W-1:0]           c_product,
	input  logic                        c_special_nan,
	input  logic                        c_special_nv,
	input  logic                        c_special_inf,
	input  logic                        c_special_zero,
	input  rnd_mode_t                   c_rnd,
	input  logic [TAG_W-1:0]            c_rd,
	output logic                        valid,
	output logic [FLEN-1:0]             res,
	output logic [4:0]                  exceptions,
	output logic [TAG_W-1:0]            rd_out
);

	logic                        prod_top;
	logic [PROD_W-1:0]           norm;
	logic [MANT_W-1:0]           mant;
	logic                        guard;
	logic                        rnd_bit;
	logic                        sticky;
	logic                        inexact;
	logic                        inc;
	logic [MANT_W:0]             mant_r;
	logic                        carry;
	logic [FRAC_W-1:0]           frac;
	logic signed [EXP_SUM_W-1:0] exp_n;
	logic signed [EXP_SUM_W-1:0] exp_r;
	logic                        overflow;
	logic                        underflow;
	logic                        ovf_to_inf;

	assign valid  = c_valid;
	assign rd_out = c_rd;

	// product of two mantissas in [1,2) lies in [1,4)
	// with the top bit set the binary point moves one place left
	assign prod_top = c_product[PROD_W-1];
	assign norm     = prod_top ? c_product : {c_product[PROD_W-2:0], 1'b0};
	assign exp_n    = c_exp_sum + EXP_SUM_W'(EXP_BIAS) + EXP_SUM_W'(prod_top);	// biased

	// kept mantissa, then guard, round and sticky below it
	assign mant    = norm[PROD_W-1 -: MANT_W];
	assign guard   = norm[PROD_W-MANT_W-1];
	assign rnd_bit = norm[PROD_W-MANT_W-2];
	assign sticky  = |norm[PROD_W-MANT_W-3:0];
	assign inexact = guard | rnd_bit | sticky;

	always_comb begin
		case (c_rnd)
			RNE: inc = guard && (rnd_bit || sticky || mant[0]);	// ties go to even
			RTZ: inc = 1'b0;
			RDN: inc = inexact && c_sign;
			RUP: inc = inexact && !c_sign;
			RMM: inc = guard;
			default: inc = 1'b0;
		endcase
	end

	assign mant_r = {1'b0, mant} + (MANT_W+1)'(inc);
	assign carry  = mant_r[MANT_W];	// rounded up to 2.0

	// renormalize after a carry out of rounding
	assign frac  = carry ? mant_r[MANT_W-1:1] : mant_r[FRAC_W-1:0];
	assign exp_r = exp_n + EXP_SUM_W'(carry);

	assign overflow  = exp_r > EXP_MAX;
	assign underflow = exp_r < 1;	// no subnormal results

	// modes that round away from zero saturate to infinity
	assign ovf_to_inf = (c_rnd == RNE) || (c_rnd == RMM) ||
		(c_rnd == RUP && !c_sign) || (c_rnd == RDN && c_sign);

	always_comb begin
		res        = {c_sign, exp_r[EXP_W-1:0], frac};
		exceptions = '0;
		if (c_special_nan) begin
			res = QNAN;
			exceptions[FLAG_NV] = c_special_nv;	// signalling nan or inf*0
		end else if (c_special_inf) begin
			res = {c_sign, {EXP_W{1'b1}}, {FRAC_W{1'b0}}};
		end else if (c_special_zero) begin
			res = {c_sign, {(FLEN-1){1'b0}}};
		end else if (overflow) begin
			if (ovf_to_inf) begin
				res = {c_sign, {EXP_W{1'b1}}, {FRAC_W{1'b0}}};
			end else begin
				res = {c_sign, EXP_W'(EXP_MAX), {FRAC_W{1'b1}}};	// largest finite
			end
			exceptions[FLAG_OF] = 1'b1;
			exceptions[FLAG_NX] = 1'b1;
		end else if (underflow) begin
			// flush to signed zero
			res = {c_sign, {(FLEN-1){1'b0}}};
			exceptions[FLAG_UF] = 1'b1;
			exceptions[FLAG_NX] = 1'b1;
		end else begin
			exceptions[FLAG_NX] = inexact;
		end
		exceptions[FLAG_DZ] = 1'b0;	// a multiply never divides by zero
	end

endmodule

//--- fp_mantissa_multiply.sv
// mantissa product stage
`timescale 1ns/1ps

module fp_mantissa_multiply import fp_pkg::*; (
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        b_valid,
	input  logic                        b_sign,
	input  logic signed [EXP_SUM_W-1:0] b_exp_sum,
	input  logic [MANT_W-1:0]           b_mant_1,
	input  logic [MANT_W-1:0]           b_mant_2,
	input  logic                        b_special_nan,
	input  logic                        b_special_nv,
	input  logic                        b_special_inf,
	input  logic                        b_special_zero,
	input  rnd_mode_t                   b_rnd,
	input  logic [TAG_W-1:0]            b_rd,
	output logic                        c_valid,
	output logic                        c_sign,
	output logic signed [EXP_SUM_W-1:0] c_exp_sum,
	output logic [PROD_W-1:0]           c_product,
	output logic                        c_special_nan,
	output logic                        c_special_nv,
	output logic                        c_special_inf,
	output logic                        c_special_zero,
	output rnd_mode_t                   c_rnd,
	output logic [TAG_W-1:0]            c_rd
);

	logic [PROD_W-1:0] product;

	// behavioural 24x24 unsigned multiply
	// a real datapath would drop in a multiplier array here
	assign product = PROD_W'(b_mant_1) * PROD_W'(b_mant_2);

	always_ff @(posedge clk) begin
		if (reset) begin
			c_valid <= 1'b0;
		end else begin
			c_valid <= b_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (b_valid) begin
			c_sign         <= b_sign;
			c_exp_sum      <= b_exp_sum;
			c_product      <= product;
			c_special_nan  <= b_special_nan;
			c_special_nv   <= b_special_nv;
			c_special_inf  <= b_special_inf;
			c_special_zero <= b_special_zero;
			c_rnd          <= b_rnd;
			c_rd           <= b_rd;
		end
	end

endmodule

//--- fp_operand_unpack.sv
// operand unpack stage
`timescale 1ns/1ps

module fp_operand_unpack import fp_pkg::*; (
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        start,
	input  logic [FLEN-1:0]             in_1,
	input  logic [FLEN-1:0]             in_2,
	input  rnd_mode_t                   rnd,
	input  logic [TAG_W-1:0]            rd,
	output logic                        b_valid,
	output logic                        b_sign,
	output logic signed [EXP_SUM_W-1:0] b_exp_sum,
	output logic [MANT_W-1:0]           b_mant_1,
	output logic [MANT_W-1:0]           b_mant_2,
	output logic                        b_special_nan,
	output logic                        b_special_nv,
	output logic                        b_special_inf,
	output logic                        b_special_zero,
	output rnd_mode_t                   b_rnd,
	output logic [TAG_W-1:0]            b_rd
);

	logic [FLEN-1:0]   op [2];
	logic [EXP_W-1:0]  op_exp [2];
	logic [FRAC_W-1:0] op_frac [2];
	logic [MANT_W-1:0] op_mant [2];
	logic [1:0]        op_sign;
	logic [1:0]        op_nan;
	logic [1:0]        op_snan;
	logic [1:0]        op_inf;
	logic [1:0]        op_zero;

	logic inf_times_zero;
	logic special_nan;
	logic special_nv;
	logic special_inf;
	logic special_zero;
	logic signed [EXP_SUM_W-1:0] exp_sum;

	assign op[0] = in_1;
	assign op[1] = in_2;

	// both operands are classified the same way
	always_comb begin
		for (int i = 0; i < 2; i++) begin
			op_sign[i] = op[i][FLEN-1];
			op_exp[i]  = op[i][FLEN-2 -: EXP_W];
			op_frac[i] = op[i][FRAC_W-1:0];
			op_nan[i]  = (&op_exp[i]) && (|op_frac[i]);
			op_snan[i] = op_nan[i] && !op_frac[i][FRAC_W-1];	// quiet bit clear
			op_inf[i]  = (&op_exp[i]) && !(|op_frac[i]);
			op_zero[i] = op_exp[i] == '0;	// subnormals flush here
			op_mant[i] = op_zero[i] ? '0 : {1'b1, op_frac[i]};
		end
	end

	// special outcome, decided once and forwarded down the pipe
	assign inf_times_zero = (op_inf[0] && op_zero[1]) || (op_inf[1] && op_zero[0]);
	assign special_nan    = (|op_nan) || inf_times_zero;
	assign special_nv     = (|op_snan) || inf_times_zero;
	assign special_inf    = (|op_inf) && !special_nan;
	assign special_zero   = (|op_zero) && !special_nan && !special_inf;

	// unbiased exponent sum
	assign exp_sum = EXP_SUM_W'(op_exp[0]) + EXP_SUM_W'(op_exp[1]) - EXP_SUM_W'(2 * EXP_BIAS);

	always_ff @(posedge clk) begin
		if (reset) begin
			b_valid <= 1'b0;
		end else begin
			b_valid <= start;
		end
	end

	// payload only moves when an operation starts
	always_ff @(posedge clk) begin
		if (start) begin
			b_sign         <= op_sign[0] ^ op_sign[1];
			b_exp_sum      <= exp_sum;
			b_mant_1       <= op_mant[0];
			b_mant_2       <= op_mant[1];
			b_special_nan  <= special_nan;
			b_special_nv   <= special_nv;
			b_special_inf  <= special_inf;
			b_special_zero <= special_zero;
			b_rnd          <= rnd;
			b_rd           <= rd;
		end
	end

endmodule

//--- fp_pkg.sv
// single precision multiplier definitions
package fp_pkg;

	// ieee 754 binary32 layout
	localparam int FLEN   = 32;
	localparam int EXP_W  = 8;
	localparam int FRAC_W = 23;
	localparam int MANT_W = FRAC_W + 1;	// with hidden bit
	localparam int PROD_W = 2 * MANT_W;

	localparam int EXP_BIAS = 127;
	localparam int EXP_MAX  = 254;	// largest biased exponent of a finite value

	// signed internal exponent, wide enough for sums of two unbiased exponents
	localparam int EXP_SUM_W = 10;

	// destination tag carried next to each operation
	localparam int TAG_W = 6;

	localparam logic [FLEN-1:0] QNAN = 32'h7fc0_0000;	// canonical quiet nan

	// bit positions in the exceptions word
	localparam int FLAG_NV = 4;	// invalid
	localparam int FLAG_DZ = 3;	// divide by zero
	localparam int FLAG_OF = 2;	// overflow
	localparam int FLAG_UF = 1;	// underflow
	localparam int FLAG_NX = 0;	// inexact

	// rounding modes, same encoding as the frm field
	typedef enum logic [2:0] {
		RNE = 3'd0,	// nearest, ties to even
		RTZ = 3'd1,	// toward zero
		RDN = 3'd2,	// toward minus infinity
		RUP = 3'd3,	// toward plus infinity
		RMM = 3'd4	// nearest, ties away from zero
	} rnd_mode_t;

endpackage
